//--- src/gain_select_pkg.sv
// ************************************************************
// Shared definitions for the gain-selection front end
// Mode encodings, FIFO geometry, pointer offsets and the
// 13-bit output word, referenced by scoped names only
// ************************************************************

`default_nettype none

package gain_select_pkg;

	// Gain selection mode
	typedef enum logic [1:0] {
		MODE_AUTO8     = 2'b00,
		MODE_AUTO16    = 2'b01,
		MODE_FORCE_G10 = 2'b10,
		MODE_FORCE_G1  = 2'b11
	} gain_mode_t;

	// Sample width and circular buffer geometry
	localparam int DATA_W_DEF = 12;
	localparam int FIFO_DEPTH = 8;
	localparam int PTR_W      = 3;

	// Offsets behind the write slot, modulo FIFO_DEPTH
	localparam logic [PTR_W-1:0] RD_LAG     = 3'd6;
	localparam logic [PTR_W-1:0] REF_LAG_8  = 3'd3;
	localparam logic [PTR_W-1:0] REF_LAG_16 = 3'd1;

	// Selection window lengths
	localparam int WIN_SHORT = 8;
	localparam int WIN_LONG  = 16;

	// Output word split for the baseline test
	localparam int BASE_W = 6;
	localparam int HEAD_W = DATA_W_DEF + 1 - BASE_W;

	// Gain bit on top, 1 means x1
	typedef struct packed {
		logic                  g1;
		logic [DATA_W_DEF-1:0] sample;
	} enc_smp_t;

	typedef struct packed {
		logic [HEAD_W-1:0] head;
		logic [BASE_W-1:0] base;
	} enc_base_t;

	// Same 13 bits, seen as sample or as baseline candidate
	typedef union packed {
		enc_smp_t  smp;
		enc_base_t bl;
	} enc_word_u;

endpackage

`default_nettype wire

//--- src/gain_mode_decode.sv
// ************************************************************
// Mode and threshold decoder
// Registers the gain mode and the shifted saturation value,
// then hands one-hot control levels to the sample buffer
// and the encoder, one edge after any input change
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module gain_mode_decode #(
	parameter int DATA_W = 12
) (
	input  wire                         CLK,
	input  wire                         rst_b,
	input  gain_select_pkg::gain_mode_t gain_mode,
	input  wire [DATA_W-1:0]            sat_value,
	input  wire [1:0]                   sat_shift,
	output gain_select_pkg::gain_mode_t mode_q,
	output logic                        win_long,
	output logic                        force_g1,
	output logic                        force_g10,
	output logic                        wide_head,
	output logic [DATA_W-1:0]           sat_thresh
);

	// ************************************************************
	// Registered mode and threshold
	// ************************************************************

	always_ff @(posedge CLK) begin
		if (!rst_b) begin
			mode_q <= gain_select_pkg::MODE_AUTO8;
			// Highest threshold so nothing saturates out of reset
			sat_thresh <= '1;
		end else begin
			mode_q <= gain_mode;
			sat_thresh <= sat_value >> sat_shift;
		end
	end

	// ************************************************************
	// Control levels from the registered mode
	// ************************************************************

	// Long window only in AUTO16
	assign win_long = (mode_q == gain_select_pkg::MODE_AUTO16);

	// Forced gains bypass the look-ahead test
	assign force_g1 = (mode_q == gain_select_pkg::MODE_FORCE_G1);
	assign force_g10 = (mode_q == gain_select_pkg::MODE_FORCE_G10);

	// Automatic modes keep the gain bit in the baseline head
	assign wide_head = ~mode_q[1];

	// Buffer must never see both forcing levels at once
	a_force_onehot: assert property (
		@(posedge CLK) disable iff (!rst_b)
		!(force_g1 && force_g10)
	);

endmodule

`default_nettype wire

//--- src/gain_select_fifo.sv
// ************************************************************
// Gain-selection buffer
// Two circular sample buffers share one write pointer; the
// read slot trails it, a look-ahead slot on the x10 path is
// tested against the threshold and the result feeds the
// short or long selection window that picks x1 or x10
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module gain_select_fifo #(
	parameter int DATA_W = 12
) (
	input  wire                         CLK,
	input  wire                         rst_b,
	input  wire [DATA_W-1:0]            sample_g1,
	input  wire [DATA_W-1:0]            sample_g10,
	input  gain_select_pkg::gain_mode_t mode_q,
	input  wire                         win_long,
	input  wire                         force_g1,
	input  wire                         force_g10,
	input  wire [DATA_W-1:0]            sat_thresh,
	output logic [DATA_W-1:0]           sel_sample,
	output logic                        sel_g1
);

	localparam int PTR_W = gain_select_pkg::PTR_W;

	// Sample storage
	logic [DATA_W-1:0] fifo_g1 [gain_select_pkg::FIFO_DEPTH];
	logic [DATA_W-1:0] fifo_g10 [gain_select_pkg::FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] ref_ptr;

	logic [DATA_W-1:0] ref_g10;
	logic              ref_sat;

	// Selection windows, one per window length
	logic [gain_select_pkg::WIN_SHORT-1:0] win_short_q;
	logic [gain_select_pkg::WIN_LONG-1:0]  win_long_q;

	// ************************************************************
	// Write side
	// ************************************************************

	// Free running, one slot per cycle
	always_ff @(posedge CLK) begin
		if (!rst_b) begin
			wr_ptr <= '0;
		end else begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_b) begin
			for (int i = 0; i < gain_select_pkg::FIFO_DEPTH; i++) begin
				fifo_g1[i] <= '0;
				fifo_g10[i] <= '0;
			end
		end else begin
			fifo_g1[wr_ptr] <= sample_g1;
			fifo_g10[wr_ptr] <= sample_g10;
		end
	end

	// ************************************************************
	// Read and look-ahead slots
	// ************************************************************

	// Oldest live sample, written RD_LAG edges ago
	assign rd_ptr = wr_ptr - gain_select_pkg::RD_LAG;

	// Look further ahead with the long window
	assign ref_ptr = win_long ? (wr_ptr - gain_select_pkg::REF_LAG_16)
	                          : (wr_ptr - gain_select_pkg::REF_LAG_8);

	assign ref_g10 = fifo_g10[ref_ptr];

	// Forcing overrides the threshold compare
	always_comb begin
		if (force_g1) begin
			ref_sat = 1'b1;
		end else if (force_g10) begin
			ref_sat = 1'b0;
		end else begin
			ref_sat = (ref_g10 >= sat_thresh);
		end
	end

	// ************************************************************
	// Selection windows
	// ************************************************************

	// Short window runs in AUTO8 and FORCE_G1
	always_ff @(posedge CLK) begin
		if (!rst_b || win_long || force_g10) begin
			win_short_q <= '0;
		end else begin
			win_short_q <= {win_short_q[gain_select_pkg::WIN_SHORT-2:0], ref_sat};
		end
	end

	// Long window runs in AUTO16 only
	always_ff @(posedge CLK) begin
		if (!rst_b || !win_long) begin
			win_long_q <= '0;
		end else begin
			win_long_q <= {win_long_q[gain_select_pkg::WIN_LONG-2:0], ref_sat};
		end
	end

	// Any saturation in the window picks x1
	assign sel_g1 = (|win_short_q) || (|win_long_q);
	assign sel_sample = sel_g1 ? fifo_g1[rd_ptr] : fifo_g10[rd_ptr];

	// Window not selected by the decoded mode empties on the next edge
	a_short_idle: assert property (
		@(posedge CLK) disable iff (!rst_b)
		(mode_q inside {gain_select_pkg::MODE_AUTO16, gain_select_pkg::MODE_FORCE_G10})
		|=> (win_short_q == '0)
	);

	a_long_idle: assert property (
		@(posedge CLK) disable iff (!rst_b)
		(mode_q != gain_select_pkg::MODE_AUTO16) |=> (win_long_q == '0)
	);

	// Forced x10 long enough flushes both windows
	a_force_g10: assert property (
		@(posedge CLK) disable iff (!rst_b)
		force_g10 [*17] |-> !sel_g1
	);

endmodule

`default_nettype wire

//--- src/baseline_encoder.sv
// ************************************************************
// Output word and baseline encoder
// Packs gain bit and selected sample into the 13-bit word,
// tests the upper bits for a baseline sample and registers
// both, adding one edge to the data path
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module baseline_encoder #(
	parameter int DATA_W = 12
) (
	input  wire                        CLK,
	input  wire                        rst_b,
	input  wire [DATA_W-1:0]           sel_sample,
	input  wire                        sel_g1,
	input  wire                        wide_head,
	output gain_select_pkg::enc_word_u enc_word,
	output logic                       baseline_flag
);

	localparam int HEAD_W = gain_select_pkg::HEAD_W;

	gain_select_pkg::enc_word_u word_d;
	logic                       flag_d;

	// ************************************************************
	// Word assembly and baseline test
	// ************************************************************

	always_comb begin
		// Built through the sample view
		word_d.smp.g1 = sel_g1;
		word_d.smp.sample = sel_sample;

		// Tested through the baseline view
		if (wide_head) begin
			// Gain bit counts, so x1 words are never baseline
			flag_d = (word_d.bl.head == '0);
		end else begin
			// Forced modes ignore the gain bit
			flag_d = (word_d.bl.head[HEAD_W-2:0] == '0);
		end
	end

	// ************************************************************
	// Output registers
	// ************************************************************

	always_ff @(posedge CLK) begin
		if (!rst_b) begin
			enc_word <= '0;
			baseline_flag <= 1'b0;
		end else begin
			enc_word <= word_d;
			baseline_flag <= flag_d;
		end
	end

	// In automatic modes a baseline word always carries x10
	a_base_gain: assert property (
		@(posedge CLK) disable iff (!rst_b)
		(baseline_flag && $past(wide_head)) |-> (enc_word.smp.g1 == 1'b0)
	);

endmodule

`default_nettype wire

//--- src/gain_select_top.sv
// ************************************************************
// Gain-selection front end, top level
// Decoder, sample buffer and output encoder in a chain;
// one 13-bit word leaves every cycle, six edges after the
// samples that produced it were written
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module gain_select_top #(
	parameter int DATA_W = gain_select_pkg::DATA_W_DEF
) (
	input  wire                         CLK,
	input  wire                         rst_b,
	input  gain_select_pkg::gain_mode_t gain_mode,
	input  wire [DATA_W-1:0]            sample_g1,
	input  wire [DATA_W-1:0]            sample_g10,
	input  wire [DATA_W-1:0]            sat_value,
	input  wire [1:0]                   sat_shift,
	output logic [DATA_W:0]             enc_word,
	output logic                        baseline_flag
);

	// Decoder to buffer
	gain_select_pkg::gain_mode_t mode_q;
	logic                        win_long;
	logic                        force_g1;
	logic                        force_g10;
	logic [DATA_W-1:0]           sat_thresh;

	// Decoder to encoder
	logic wide_head;

	// Buffer to encoder
	logic [DATA_W-1:0] sel_sample;
	logic              sel_g1;

	gain_mode_decode #(.DATA_W(DATA_W)) u_decode (
		.CLK        (CLK),
		.rst_b      (rst_b),
		.gain_mode  (gain_mode),
		.sat_value  (sat_value),
		.sat_shift  (sat_shift),
		.mode_q     (mode_q),
		.win_long   (win_long),
		.force_g1   (force_g1),
		.force_g10  (force_g10),
		.wide_head  (wide_head),
		.sat_thresh (sat_thresh)
	);

	gain_select_fifo #(.DATA_W(DATA_W)) u_fifo (
		.CLK        (CLK),
		.rst_b      (rst_b),
		.sample_g1  (sample_g1),
		.sample_g10 (sample_g10),
		.mode_q     (mode_q),
		.win_long   (win_long),
		.force_g1   (force_g1),
		.force_g10  (force_g10),
		.sat_thresh (sat_thresh),
		.sel_sample (sel_sample),
		.sel_g1     (sel_g1)
	);

	// Union output lands on the plain word port
	baseline_encoder #(.DATA_W(DATA_W)) u_encoder (
		.CLK           (CLK),
		.rst_b         (rst_b),
		.sel_sample    (sel_sample),
		.sel_g1        (sel_g1),
		.wide_head     (wide_head),
		.enc_word      (enc_word),
		.baseline_flag (baseline_flag)
	);

endmodule

`default_nettype wire

//--- tests/gain_select_tb.sv
// ************************************************************
// Self-checking testbench for the gain-selection front end
// Applies a table of mode, threshold and sample patterns,
// predicts each output word from the samples driven seven
// cycles before and checks gain bit, sample and baseline flag
// ************************************************************

`timescale 1ns/1ps
`default_nettype none

module gain_select_tb;

	localparam int DATA_W         = gain_select_pkg::DATA_W_DEF;
	localparam int CLK_PERIOD     = 100;
	localparam int CYCLES_PER_ROW = 40;
	localparam int SETTLE_CYCLES  = 24;
	// Falling edges between driving a sample and seeing its word
	localparam int LATENCY        = 7;
	localparam int NUM_ROWS       = 13;
	// Whole table plus reset and some slack, in ns
	localparam int TIMEOUT_NS     = (NUM_ROWS * CYCLES_PER_ROW + 40) * CLK_PERIOD;

	// Codes for the expected flag column
	localparam logic [1:0] FLAG_0    = 2'd0;
	localparam logic [1:0] FLAG_1    = 2'd1;
	localparam logic [1:0] FLAG_CALC = 2'd2;

	// One stimulus row with its expected results
	typedef struct packed {
		gain_select_pkg::gain_mode_t mode;
		logic [DATA_W-1:0]           sat_value;
		logic [1:0]                  sat_shift;
		logic                        g10_rand;
		logic [DATA_W-1:0]           g10_const;
		logic                        g1_rand;
		logic [DATA_W-1:0]           g1_const;
		logic                        exp_g1;
		logic                        exp_src_g1;
		logic [1:0]                  exp_flag;
	} row_t;

	// DUT connections
	logic                        CLK;
	logic                        rst_b;
	gain_select_pkg::gain_mode_t gain_mode;
	logic [DATA_W-1:0]           sample_g1;
	logic [DATA_W-1:0]           sample_g10;
	logic [DATA_W-1:0]           sat_value;
	logic [1:0]                  sat_shift;
	logic [DATA_W:0]             enc_word;
	logic                        baseline_flag;

	row_t table_rows[$];

	// Reference model history, index 0 is the newest sample
	logic [DATA_W-1:0] hist_g1 [LATENCY];
	logic [DATA_W-1:0] hist_g10 [LATENCY];

	int err_count;
	int tests_passed;
	int tests_failed;

	gain_select_top #(.DATA_W(DATA_W)) uut (
		.CLK           (CLK),
		.rst_b         (rst_b),
		.gain_mode     (gain_mode),
		.sample_g1     (sample_g1),
		.sample_g10    (sample_g10),
		.sat_value     (sat_value),
		.sat_shift     (sat_shift),
		.enc_word      (enc_word),
		.baseline_flag (baseline_flag)
	);

	// ************************************************************
	// Clock and watchdog
	// ************************************************************

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Test FAILED");
		$finish;
	end

	// ************************************************************
	// Helpers
	// ************************************************************

	task automatic check_val(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (expected !== actual) begin
			$display("** Error: %s expected 0x%0h actual 0x%0h at %0d ns",
				name, expected, actual, $time);
			err_count++;
		end
	endtask

	// Low amplitude so some samples fall in the baseline range
	function automatic logic [DATA_W-1:0] random_low_sample();
		return DATA_W'($urandom & 32'h0FF);
	endfunction

	function automatic logic [DATA_W-1:0] pick_sample(
		input logic              use_rand,
		input logic [DATA_W-1:0] const_v
	);
		if (use_rand) begin
			return random_low_sample();
		end
		return const_v;
	endfunction

	task automatic add_row(
		input gain_select_pkg::gain_mode_t mode,
		input logic [DATA_W-1:0]           sat_v,
		input logic [1:0]                  shift,
		input logic                        g10_rand,
		input logic [DATA_W-1:0]           g10_const,
		input logic                        g1_rand,
		input logic [DATA_W-1:0]           g1_const,
		input logic                        exp_g1,
		input logic                        exp_src_g1,
		input logic [1:0]                  exp_flag
	);
		row_t r;
		r.mode = mode;
		r.sat_value = sat_v;
		r.sat_shift = shift;
		r.g10_rand = g10_rand;
		r.g10_const = g10_const;
		r.g1_rand = g1_rand;
		r.g1_const = g1_const;
		r.exp_g1 = exp_g1;
		r.exp_src_g1 = exp_src_g1;
		r.exp_flag = exp_flag;
		table_rows.push_back(r);
	endtask

	// ************************************************************
	// Stimulus table
	// ************************************************************

	task automatic build_table();
		// Forced x10 and x1 with random data on both paths
		add_row(gain_select_pkg::MODE_FORCE_G10, 12'hFFF, 2'd0, 1'b1, 12'h000, 1'b1, 12'h000,
			1'b0, 1'b0, FLAG_CALC);
		add_row(gain_select_pkg::MODE_FORCE_G1, 12'hFFF, 2'd0, 1'b1, 12'h000, 1'b1, 12'h000,
			1'b1, 1'b1, FLAG_CALC);
		// AUTO8 at and just below threshold 0x400
		add_row(gain_select_pkg::MODE_AUTO8, 12'h800, 2'd1, 1'b0, 12'h400, 1'b0, 12'h155,
			1'b1, 1'b1, FLAG_0);
		add_row(gain_select_pkg::MODE_AUTO8, 12'h800, 2'd1, 1'b0, 12'h3FF, 1'b1, 12'h000,
			1'b0, 1'b0, FLAG_0);
		// AUTO16 with the same pair
		add_row(gain_select_pkg::MODE_AUTO16, 12'h800, 2'd1, 1'b0, 12'h400, 1'b1, 12'h000,
			1'b1, 1'b1, FLAG_0);
		add_row(gain_select_pkg::MODE_AUTO16, 12'h800, 2'd1, 1'b0, 12'h3FF, 1'b1, 12'h000,
			1'b0, 1'b0, FLAG_0);
		// Shift sweep on a fixed 0x200
		add_row(gain_select_pkg::MODE_AUTO8, 12'hFFF, 2'd0, 1'b0, 12'h200, 1'b1, 12'h000,
			1'b0, 1'b0, FLAG_0);
		add_row(gain_select_pkg::MODE_AUTO8, 12'hFFF, 2'd3, 1'b0, 12'h200, 1'b1, 12'h000,
			1'b1, 1'b1, FLAG_0);
		// Baseline flag in automatic modes
		add_row(gain_select_pkg::MODE_AUTO8, 12'hFFF, 2'd0, 1'b1, 12'h000, 1'b1, 12'h000,
			1'b0, 1'b0, FLAG_CALC);
		add_row(gain_select_pkg::MODE_AUTO8, 12'hFFF, 2'd0, 1'b0, 12'h020, 1'b1, 12'h000,
			1'b0, 1'b0, FLAG_1);
		add_row(gain_select_pkg::MODE_AUTO16, 12'h600, 2'd2, 1'b0, 12'hE00, 1'b0, 12'h300,
			1'b1, 1'b1, FLAG_0);
		// Zero threshold must not override forced x10
		add_row(gain_select_pkg::MODE_FORCE_G10, 12'h000, 2'd0, 1'b1, 12'h000, 1'b1, 12'h000,
			1'b0, 1'b0, FLAG_CALC);
		// Forced x1 baseline ignores the gain bit
		add_row(gain_select_pkg::MODE_FORCE_G1, 12'hFFF, 2'd0, 1'b1, 12'h000, 1'b0, 12'h03F,
			1'b1, 1'b1, FLAG_1);
	endtask

	// ************************************************************
	// Row runner with reference model
	// ************************************************************

	task automatic run_row(input int idx);
		row_t                       r;
		gain_select_pkg::enc_word_u got;
		logic [DATA_W-1:0]          exp_sample;
		logic                       exp_flag;
		logic [DATA_W-1:0]          new_g1;
		logic [DATA_W-1:0]          new_g10;
		int                         errs_before;
		r = table_rows[idx];
		errs_before = err_count;
		for (int c = 0; c < CYCLES_PER_ROW; c++) begin
			@(negedge CLK);
			// Outputs are stable here, half a period after the edge
			if (c >= SETTLE_CYCLES) begin
				got = enc_word;
				exp_sample = r.exp_src_g1 ? hist_g1[LATENCY-1] : hist_g10[LATENCY-1];
				if (r.exp_flag == FLAG_CALC) begin
					// Upper six sample bits zero, gain bit too in automatic modes
					exp_flag = (exp_sample[DATA_W-1:gain_select_pkg::BASE_W] == '0)
						&& (r.mode[1] || !r.exp_g1);
				end else begin
					exp_flag = r.exp_flag[0];
				end
				check_val("enc_word.g1", 32'(r.exp_g1), 32'(got.smp.g1));
				check_val("enc_word.sample", 32'(exp_sample), 32'(got.smp.sample));
				check_val("baseline_flag", 32'(exp_flag), 32'(baseline_flag));
			end
			if (c == 0) begin
				gain_mode = r.mode;
				sat_value = r.sat_value;
				sat_shift = r.sat_shift;
			end
			new_g1 = pick_sample(r.g1_rand, r.g1_const);
			new_g10 = pick_sample(r.g10_rand, r.g10_const);
			sample_g1 = new_g1;
			sample_g10 = new_g10;
			for (int i = LATENCY - 1; i > 0; i--) begin
				hist_g1[i] = hist_g1[i-1];
				hist_g10[i] = hist_g10[i-1];
			end
			hist_g1[0] = new_g1;
			hist_g10[0] = new_g10;
		end
		if (err_count == errs_before) begin
			tests_passed++;
			$display("row %0d %s sat 0x%03h shift %0d passed",
				idx, r.mode.name(), r.sat_value, r.sat_shift);
		end else begin
			tests_failed++;
			$display("row %0d %s sat 0x%03h shift %0d failed with %0d mismatches",
				idx, r.mode.name(), r.sat_value, r.sat_shift, err_count - errs_before);
		end
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************

	initial begin
		void'($urandom(86444));
		rst_b = 1'b0;
		gain_mode = gain_select_pkg::MODE_FORCE_G10;
		sample_g1 = '0;
		sample_g10 = '0;
		sat_value = '1;
		sat_shift = 2'd0;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < LATENCY; i++) begin
			hist_g1[i] = '0;
			hist_g10[i] = '0;
		end
		build_table();

		// Three rising edges in reset, release on a falling edge
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		rst_b = 1'b1;

		for (int i = 0; i < table_rows.size(); i++) begin
			run_row(i);
		end

		$display("Summary: %0d rows passed, %0d rows failed, %0d mismatches",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
src/gain_select_pkg.sv
src/gain_mode_decode.sv
src/gain_select_fifo.sv
src/baseline_encoder.sv
src/gain_select_top.sv
tests/gain_select_tb.sv

//--- Makefile
# Verilator build and run for the gain-selection front end

VERILATOR ?= verilator
TOP       ?= gain_select_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
